//--- files.f
conv_pkg.sv
conv_wb_regs.sv
conv_window_ctrl.sv
conv_mac_lane.sv
conv_result_drain.sv
conv_top.sv
conv_top_chk.sv
tb_conv_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_conv_top
FILE_LIST ?= files.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal
SIM_ARGS ?= +verilator+error+limit+100
PASS_MSG := all tests passed
FAIL_MSG := tests failed

SOURCES := $(shell grep -v '^+' $(FILE_LIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM_BIN)
	-./$(SIM_BIN) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -qx "$(FAIL_MSG)" $(LOG); then echo "simulation FAILED"; exit 1; \
	elif grep -qx "$(PASS_MSG)" $(LOG); then echo "simulation PASSED"; \
	else echo "simulation FAILED: no pass message in $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb_conv_top.sv
`timescale 1ns/1ps

module tb_conv_top;
    import conv_pkg::*;

    localparam int max_cols = 64;
    localparam int ack_limit = 64;
    localparam int poll_limit = 64;

    logic clk;
    logic nrst;
    logic cyc;
    logic stb;
    logic we;
    logic [bus_adr_w-1:0] adr;
    logic [bus_dat_w-1:0] dat_w;
    logic [bus_dat_w-1:0] dat_r;
    logic ack;

    logic signed [pix_w-1:0] weights [n_lanes][n_taps];
    logic [pix_w-1:0] pixels [max_cols][k_dim];
    logic [res_w-1:0] exp_q [$];
    int col_count;
    int strip_start;
    int stall_count;

    conv_top dut0 (
        .clk   (clk),
        .nrst  (nrst),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .dat_w (dat_w),
        .dat_r (dat_r),
        .ack   (ack)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // the dot product of the five columns ending at last_col keeps only the low 32 bits.
    function automatic logic [res_w-1:0] expected_result(input int lane, input int last_col);
        logic [res_w-1:0] acc;
        longint prod;
        int c;
        acc = '0;
        for (int j = 0; j < k_dim; j++)
        begin
            c = last_col - (k_dim - 1) + j;
            for (int r = 0; r < k_dim; r++)
            begin
                prod = longint'(pixels[c][r]) * longint'(weights[lane][j * k_dim + r]);
                acc = acc + prod[res_w-1:0];
            end
        end
        return acc;
    endfunction

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("tests failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("[ERROR] %s expected 0x%08h actual 0x%08h", name, expected, actual);
            $display("tests failed");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    // one bus transfer that gives up after limit cycles without ack.
    task automatic bus_cycle(input logic w, input logic [bus_adr_w-1:0] a,
                             input logic [bus_dat_w-1:0] d, input int limit,
                             output logic [bus_dat_w-1:0] q, output logic acked);
        int waited;
        waited = 0;
        acked = 1'b0;
        q = '0;
        @(posedge clk);
        cyc <= 1'b1;
        stb <= 1'b1;
        we <= w;
        adr <= a;
        dat_w <= d;
        while (!acked && waited < limit)
        begin
            @(negedge clk);
            acked = ack;
            q = dat_r;
            waited++;
        end
        @(posedge clk);
        cyc <= 1'b0;
        stb <= 1'b0;
        we <= 1'b0;
    endtask

    task automatic bus_write(input logic [bus_adr_w-1:0] a, input logic [bus_dat_w-1:0] d);
        logic [bus_dat_w-1:0] q;
        logic ok;
        bus_cycle(1'b1, a, d, ack_limit, q, ok);
        if (!ok)
            stop_with_failure("timeout: no ack for a bus write");
    endtask

    task automatic bus_read(input logic [bus_adr_w-1:0] a, output logic [bus_dat_w-1:0] q);
        logic ok;
        bus_cycle(1'b0, a, '0, ack_limit, q, ok);
        if (!ok)
            stop_with_failure("timeout: no ack for a bus read");
    endtask

    task automatic load_weights(input logic use_random, input logic [pix_w-1:0] fixed);
        for (int l = 0; l < n_lanes; l++)
        begin
            for (int t = 0; t < n_taps; t++)
            begin
                weights[l][t] = use_random ? pix_w'($urandom) : fixed;
                bus_write(reg_weight_base + bus_adr_w'(l * 'h80 + t * 4),
                          {16'h0, weights[l][t]});
            end
        end
    endtask

    task automatic set_column(input logic use_random);
        for (int r = 0; r < k_dim; r++)
            pixels[col_count][r] = use_random ? pix_w'($urandom) : '1;
    endtask

    task automatic write_pixels(input int first, input int last);
        for (int r = first; r <= last; r++)
            bus_write(reg_pixel, {16'h0, pixels[col_count][r]});
    endtask

    // a finished column yields a window once five columns of the strip exist.
    task automatic column_done();
        if (col_count - strip_start >= k_dim - 1)
        begin
            for (int l = 0; l < n_lanes; l++)
                exp_q.push_back(expected_result(l, col_count));
        end
        col_count++;
    endtask

    task automatic send_column(input logic use_random);
        set_column(use_random);
        write_pixels(0, k_dim - 1);
        column_done();
    endtask

    task automatic read_window(input string name);
        logic [bus_dat_w-1:0] st;
        logic [bus_dat_w-1:0] got;
        int polls;
        polls = 0;
        bus_read(reg_status, st);
        while (!st[0])
        begin
            polls++;
            if (polls > poll_limit)
                stop_with_failure("timeout: no result arrived in the FIFO");
            bus_read(reg_status, st);
        end
        for (int l = 0; l < n_lanes; l++)
        begin
            if (exp_q.size() == 0)
                stop_with_failure("a result was read but none was expected");
            bus_read(reg_result, got);
            check_value($sformatf("%s lane %0d", name, l), exp_q.pop_front(), got);
        end
    endtask

    // an assertion failure in the bound checker ends the run at once.
    always @(negedge clk)
    begin
        if (dut0.chk0.fail_count != 0)
            stop_with_failure("a bus or pipeline assertion failed");
    end

    initial
    begin
        logic [bus_dat_w-1:0] st;
        logic [bus_dat_w-1:0] st2;
        logic [bus_dat_w-1:0] q;
        logic ok;
        void'($urandom(32'hc586));
        nrst = 1'b0;
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
        adr = '0;
        dat_w = '0;
        col_count = 0;
        strip_start = 0;
        stall_count = 0;
        repeat (4) @(posedge clk);
        nrst <= 1'b1;
        bus_read(reg_status, st);
        check_value("status after reset", 32'h2, st);

        // a full fill gives one window after the fifth column.
        load_weights(1'b1, '0);
        for (int i = 0; i < k_dim - 1; i++)
            send_column(1'b1);
        repeat (8) @(posedge clk);
        bus_read(reg_status, st);
        check_value("no result before fifth column", 32'h2, st);
        send_column(1'b1);
        read_window("first window");
        bus_read(reg_status, st);
        check_value("one window per fill", 32'h2, st);

        for (int i = 0; i < 12; i++)
        begin
            send_column(1'b1);
            read_window("sliding window");
        end

        // restart with a half written column pending.
        for (int i = 0; i < 2; i++)
        begin
            send_column(1'b1);
            read_window("window before restart");
        end
        set_column(1'b1);
        write_pixels(0, 2);
        bus_write(reg_ctrl, 32'h1);
        strip_start = col_count;
        for (int i = 0; i < k_dim - 1; i++)
        begin
            send_column(1'b1);
            repeat (8) @(posedge clk);
            bus_read(reg_status, st);
            check_value("no result while refilling", 32'h2, st);
        end
        send_column(1'b1);
        read_window("first window after restart");

        // stream without reading until the fifth pixel write stalls.
        for (int i = 0; i < 10; i++)
        begin
            set_column(1'b1);
            write_pixels(0, k_dim - 2);
            bus_cycle(1'b1, reg_pixel, {16'h0, pixels[col_count][k_dim-1]}, 16, q, ok);
            if (!ok)
            begin
                stall_count++;
                bus_read(reg_status, st);
                check_value("buffered windows within depth", 32'h1,
                            32'(st[7:4] <= fifo_depth));
                check_value("column slot busy during stall", 32'h0, 32'(st[1]));
                while (exp_q.size() > 0)
                    read_window("window under back-pressure");
                bus_write(reg_pixel, {16'h0, pixels[col_count][k_dim-1]});
            end
            column_done();
        end
        while (exp_q.size() > 0)
            read_window("drain after back-pressure");
        check_value("pixel writes stalled", 32'h1, 32'(stall_count > 0));

        bus_read(reg_status, st);
        check_value("status when empty", 32'h2, st);
        bus_read(reg_result, q);
        check_value("empty result read", 32'h0, q);
        bus_read(reg_status, st2);
        check_value("status after empty read", 32'h2, st2);

        // largest pixels against the most negative weights wrap the sum.
        bus_write(reg_ctrl, 32'h1);
        load_weights(1'b0, 16'h8000);
        strip_start = col_count;
        for (int i = 0; i < k_dim; i++)
            send_column(1'b0);
        read_window("extreme values");

        if (dut0.chk0.fail_count == 0)
        begin
            $display("all tests passed");
        end
        else
        begin
            $display("assertion failures seen: %0d", dut0.chk0.fail_count);
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- conv_top_chk.sv
`timescale 1ns/1ps

module conv_top_chk (
    input  logic                                          clk,
    input  logic                                          nrst,
    input  logic                                          cyc,
    input  logic                                          stb,
    input  logic                                          ack,
    input  logic                                          adv,
    input  logic                                          window_valid,
    input  conv_pkg::lane_res_t [conv_pkg::n_lanes-1:0]   lane_res,
    input  logic [conv_pkg::cnt_w-1:0]                    fifo_count
);
    import conv_pkg::*;

    int fail_count = 0;
    logic all_valid;

    always_comb
    begin
        all_valid = 1'b1;
        for (int i = 0; i < n_lanes; i++)
        begin
            all_valid = all_valid && lane_res[i].valid;
        end
    end

    ack_with_request: assert property (@(posedge clk) disable iff (!nrst) ack |-> (cyc && stb))
    else
    begin
        $error("ack seen without cyc and stb");
        fail_count++;
    end

    ack_single_cycle: assert property (@(posedge clk) disable iff (!nrst) ack |=> !ack)
    else
    begin
        $error("ack held for two cycles");
        fail_count++;
    end

    window_needs_adv: assert property (@(posedge clk) disable iff (!nrst) window_valid |-> adv)
    else
    begin
        $error("window_valid while the pipeline is stopped");
        fail_count++;
    end

    // a push happens when adv is high and every lane holds a result.
    no_push_when_full: assert property (@(posedge clk) disable iff (!nrst)
        (fifo_count == cnt_w'(fifo_depth)) |-> !(adv && all_valid))
    else
    begin
        $error("result FIFO written while full");
        fail_count++;
    end

endmodule

bind conv_top conv_top_chk chk0 (
    .clk          (clk),
    .nrst         (nrst),
    .cyc          (cyc),
    .stb          (stb),
    .ack          (ack),
    .adv          (adv),
    .window_valid (window_valid),
    .lane_res     (lane_res),
    .fifo_count   (fifo_count)
);

//--- conv_top.sv
`timescale 1ns/1ps

module conv_top (
    input  logic                              clk,
    input  logic                              nrst,
    input  logic                              cyc,
    input  logic                              stb,
    input  logic                              we,
    input  logic [conv_pkg::bus_adr_w-1:0]    adr,
    input  logic [conv_pkg::bus_dat_w-1:0]    dat_w,
    output logic [conv_pkg::bus_dat_w-1:0]    dat_r,
    output logic                              ack
);
    import conv_pkg::*;

    weight_wr_t weight_wr;
    column_t column;
    logic column_valid;
    logic column_ready;
    logic restart;
    window_t window;
    logic window_valid;
    logic adv;
    lane_res_t [n_lanes-1:0] lane_res;
    logic [res_w-1:0] result_word;
    logic [cnt_w-1:0] fifo_count;
    logic pop;

    conv_wb_regs u_regs (
        .clk          (clk),
        .nrst         (nrst),
        .cyc          (cyc),
        .stb          (stb),
        .we           (we),
        .adr          (adr),
        .dat_w        (dat_w),
        .dat_r        (dat_r),
        .ack          (ack),
        .weight_wr    (weight_wr),
        .column       (column),
        .column_valid (column_valid),
        .column_ready (column_ready),
        .restart      (restart),
        .result_word  (result_word),
        .fifo_count   (fifo_count),
        .pop          (pop)
    );

    conv_window_ctrl u_window (
        .clk          (clk),
        .nrst         (nrst),
        .restart      (restart),
        .column       (column),
        .column_valid (column_valid),
        .column_ready (column_ready),
        .adv          (adv),
        .window       (window),
        .window_valid (window_valid)
    );

    // one lane per output channel, all fed by the same window.
    for (genvar g = 0; g < n_lanes; g++)
    begin : g_lane
        conv_mac_lane #(
            .lane_idx (g)
        ) u_lane (
            .clk          (clk),
            .nrst         (nrst),
            .adv          (adv),
            .weight_wr    (weight_wr),
            .window       (window),
            .window_valid (window_valid),
            .result       (lane_res[g])
        );
    end

    conv_result_drain u_drain (
        .clk         (clk),
        .nrst        (nrst),
        .result      (lane_res),
        .adv         (adv),
        .pop         (pop),
        .result_word (result_word),
        .fifo_count  (fifo_count)
    );

endmodule

//--- conv_result_drain.sv
`timescale 1ns/1ps

module conv_result_drain (
    input  logic                                          clk,
    input  logic                                          nrst,
    input  conv_pkg::lane_res_t [conv_pkg::n_lanes-1:0]   result,
    output logic                                          adv,
    input  logic                                          pop,
    output logic [conv_pkg::res_w-1:0]                    result_word,
    output logic [conv_pkg::cnt_w-1:0]                    fifo_count
);
    import conv_pkg::*;

    logic [n_lanes-1:0][res_w-1:0] mem [fifo_depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [lane_w-1:0] lane_sel;
    logic [cnt_w-1:0] count;
    logic [n_lanes-1:0] lane_valid;
    logic push;
    logic pop_ok;
    logic pop_last;

    always_comb
    begin
        for (int i = 0; i < n_lanes; i++)
        begin
            lane_valid[i] = result[i].valid;
        end
    end

    // all lanes see the same window, so their results arrive together.
    assign push = adv && (&lane_valid);
    assign pop_ok = pop && (count != '0);
    assign pop_last = pop_ok && (lane_sel == lane_w'(n_lanes - 1));

    assign adv = (cnt_w'(fifo_depth) - count) >= cnt_w'(adv_min_free);
    assign result_word = mem[rd_ptr][lane_sel];
    assign fifo_count = count;

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            lane_sel <= '0;
            count <= '0;
        end
        else
        begin
            if (push)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_ok)
            begin
                lane_sel <= lane_sel + 1'b1;
            end
            if (pop_last)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + cnt_w'(push) - cnt_w'(pop_last);
        end
    end

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            for (int i = 0; i < n_lanes; i++)
            begin
                mem[wr_ptr][i] <= result[i].value;
            end
        end
    end

endmodule

//--- conv_mac_lane.sv
`timescale 1ns/1ps

module conv_mac_lane #(
    parameter int lane_idx = 0
) (
    input  logic                  clk,
    input  logic                  nrst,
    input  logic                  adv,
    input  conv_pkg::weight_wr_t  weight_wr,
    input  conv_pkg::window_t     window,
    input  logic                  window_valid,
    output conv_pkg::lane_res_t   result
);
    import conv_pkg::*;

    logic signed [pix_w-1:0] weights [n_taps];
    logic signed [prod_w-1:0] prod [n_taps];
    logic s1_valid;
    logic [res_w-1:0] sum_c;
    logic res_valid;
    logic signed [res_w-1:0] res_value;

    always_ff @(posedge clk)
    begin
        if (weight_wr.en && (weight_wr.lane == lane_w'(lane_idx)))
        begin
            weights[weight_wr.tap] <= weight_wr.value;
        end
    end

    // pixels are zero extended so the product keeps its sign from the weight.
    always_ff @(posedge clk)
    begin
        if (adv && window_valid)
        begin
            for (int i = 0; i < n_taps; i++)
            begin
                prod[i] <= $signed({1'b0, window.tap[i]}) * weights[i];
            end
        end
    end

    // the low 32 bits of a sum only depend on the low 32 bits of each term.
    always_comb
    begin
        sum_c = '0;
        for (int i = 0; i < n_taps; i++)
        begin
            sum_c = sum_c + prod[i][res_w-1:0];
        end
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            s1_valid <= 1'b0;
            res_valid <= 1'b0;
        end
        else if (adv)
        begin
            s1_valid <= window_valid;
            res_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk)
    begin
        if (adv && s1_valid)
        begin
            res_value <= $signed(sum_c);
        end
    end

    assign result = '{valid: res_valid, value: res_value};

endmodule

//--- conv_window_ctrl.sv
`timescale 1ns/1ps

module conv_window_ctrl (
    input  logic                 clk,
    input  logic                 nrst,
    input  logic                 restart,
    input  conv_pkg::column_t    column,
    input  logic                 column_valid,
    output logic                 column_ready,
    input  logic                 adv,
    output conv_pkg::window_t    window,
    output logic                 window_valid
);
    import conv_pkg::*;

    win_state_e state;
    logic [idx_w-1:0] col_cnt;
    logic win_pend;
    logic take;

    assign column_ready = adv;
    assign take = column_valid && column_ready;

    // a pending window is held until the lanes are allowed to move.
    assign window_valid = win_pend && adv;

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            state <= win_idle;
            col_cnt <= '0;
            win_pend <= 1'b0;
        end
        else if (restart)
        begin
            state <= win_idle;
            col_cnt <= '0;
            win_pend <= 1'b0;
        end
        else if (adv)
        begin
            win_pend <= 1'b0;
            if (take)
            begin
                case (state)
                    win_idle:
                    begin
                        state <= win_fill;
                        col_cnt <= idx_w'(1);
                    end
                    win_fill:
                    begin
                        if (col_cnt == idx_w'(k_dim - 1))
                        begin
                            state <= win_slide;
                            col_cnt <= '0;
                            win_pend <= 1'b1;
                        end
                        else
                        begin
                            col_cnt <= col_cnt + 1'b1;
                        end
                    end
                    win_slide:
                    begin
                        win_pend <= 1'b1;
                    end
                    default:
                    begin
                        state <= win_idle;
                        col_cnt <= '0;
                    end
                endcase
            end
        end
    end

    // the newest column enters at column 4 and the oldest five pixels fall out.
    // after a restart five shifts replace every tap, so fill and slide share this path.
    always_ff @(posedge clk)
    begin
        if (take)
        begin
            window.tap <= {column.row, window.tap[n_taps-1:k_dim]};
        end
    end

endmodule

//--- conv_wb_regs.sv
`timescale 1ns/1ps

module conv_wb_regs (
    input  logic                              clk,
    input  logic                              nrst,
    input  logic                              cyc,
    input  logic                              stb,
    input  logic                              we,
    input  logic [conv_pkg::bus_adr_w-1:0]    adr,
    input  logic [conv_pkg::bus_dat_w-1:0]    dat_w,
    output logic [conv_pkg::bus_dat_w-1:0]    dat_r,
    output logic                              ack,
    output conv_pkg::weight_wr_t              weight_wr,
    output conv_pkg::column_t                 column,
    output logic                              column_valid,
    input  logic                              column_ready,
    output logic                              restart,
    input  logic [conv_pkg::res_w-1:0]        result_word,
    input  logic [conv_pkg::cnt_w-1:0]        fifo_count,
    output logic                              pop
);
    import conv_pkg::*;

    logic [idx_w-1:0] row_cnt;
    logic [k_dim-2:0][pix_w-1:0] stage;
    logic is_ctrl;
    logic is_status;
    logic is_pixel;
    logic is_result;
    logic is_weight;
    logic stall;
    logic accept;
    logic wr_restart;
    logic wr_pixel;
    logic ww_en;
    logic [lane_w-1:0] ww_lane;
    logic [tap_w-1:0] ww_tap;
    logic signed [pix_w-1:0] ww_value;
    logic [bus_dat_w-1:0] rd_data;

    assign is_ctrl = (adr == reg_ctrl);
    assign is_status = (adr == reg_status);
    assign is_pixel = (adr == reg_pixel);
    assign is_result = (adr == reg_result);
    assign is_weight = (adr[bus_adr_w-1:9] == reg_weight_base[bus_adr_w-1:9])
                       && (adr[2 +: tap_w] < tap_w'(n_taps));

    // the fifth pixel waits while the previous column is still held.
    assign stall = cyc && stb && we && is_pixel && (row_cnt == idx_w'(k_dim - 1))
                   && column_valid && !column_ready;
    assign accept = cyc && stb && !ack && !stall;
    assign wr_restart = accept && we && is_ctrl && dat_w[0];
    assign wr_pixel = accept && we && is_pixel;
    assign pop = accept && !we && is_result && (fifo_count != '0);

    always_comb
    begin
        rd_data = '0;
        if (is_status)
        begin
            rd_data = {24'b0, 4'(fifo_count), 2'b00, !column_valid, (fifo_count != '0)};
        end
        else if (is_result && (fifo_count != '0))
        begin
            rd_data = result_word;
        end
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            ack <= 1'b0;
            restart <= 1'b0;
            dat_r <= '0;
            ww_en <= 1'b0;
        end
        else
        begin
            ack <= accept;
            restart <= wr_restart;
            ww_en <= accept && we && is_weight;
            if (accept && !we)
            begin
                dat_r <= rd_data;
            end
        end
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            row_cnt <= '0;
            column_valid <= 1'b0;
        end
        else if (wr_restart)
        begin
            row_cnt <= '0;
            column_valid <= 1'b0;
        end
        else
        begin
            if (column_valid && column_ready)
            begin
                column_valid <= 1'b0;
            end
            if (wr_pixel)
            begin
                if (row_cnt == idx_w'(k_dim - 1))
                begin
                    row_cnt <= '0;
                    column_valid <= 1'b1;
                end
                else
                begin
                    row_cnt <= row_cnt + 1'b1;
                end
            end
        end
    end

    // rows 0 to 3 gather in stage so a pending column is not disturbed.
    always_ff @(posedge clk)
    begin
        if (wr_pixel)
        begin
            if (row_cnt == idx_w'(k_dim - 1))
            begin
                column.row <= {dat_w[pix_w-1:0], stage};
            end
            else
            begin
                stage[row_cnt] <= dat_w[pix_w-1:0];
            end
        end
        if (accept && we && is_weight)
        begin
            ww_lane <= adr[7 +: lane_w];
            ww_tap <= adr[2 +: tap_w];
            ww_value <= dat_w[pix_w-1:0];
        end
    end

    assign weight_wr = '{en: ww_en, lane: ww_lane, tap: ww_tap, value: ww_value};

endmodule

//--- conv_pkg.sv
package conv_pkg;

    // pixels are unsigned, weights are signed two's complement.
    localparam int pix_w = 16;
    localparam int k_dim = 5;
    localparam int n_taps = 25;
    localparam int n_lanes = 4;
    localparam int res_w = 32;
    localparam int fifo_depth = 4;

    localparam int prod_w = 2 * pix_w + 1;
    localparam int lane_w = $clog2(n_lanes);
    localparam int tap_w = $clog2(n_taps);
    localparam int idx_w = $clog2(k_dim);
    localparam int ptr_w = $clog2(fifo_depth);
    localparam int cnt_w = $clog2(fifo_depth + 1);

    // two windows can sit in the lane pipelines and one more in the window register.
    localparam int adv_min_free = 3;

    localparam int bus_adr_w = 12;
    localparam int bus_dat_w = 32;

    localparam logic [bus_adr_w-1:0] reg_ctrl = 12'h000;
    localparam logic [bus_adr_w-1:0] reg_status = 12'h004;
    localparam logic [bus_adr_w-1:0] reg_pixel = 12'h008;
    localparam logic [bus_adr_w-1:0] reg_result = 12'h00C;
    localparam logic [bus_adr_w-1:0] reg_weight_base = 12'h200;

    typedef struct packed {
        logic [k_dim-1:0][pix_w-1:0] row;
    } column_t;

    // tap index is column * 5 + row, column 0 is the oldest.
    typedef struct packed {
        logic [n_taps-1:0][pix_w-1:0] tap;
    } window_t;

    typedef struct packed {
        logic en;
        logic [lane_w-1:0] lane;
        logic [tap_w-1:0] tap;
        logic signed [pix_w-1:0] value;
    } weight_wr_t;

    typedef struct packed {
        logic valid;
        logic signed [res_w-1:0] value;
    } lane_res_t;

    typedef enum logic [1:0] {
        win_idle,
        win_fill,
        win_slide
    } win_state_e;

endpackage
